/* vlog.f */
+incdir+.
cdc_fifo_pkg.sv
fifo_mem_if.sv
cdc_2phase.sv
cdc_fifo_mem.sv
cdc_fifo_src_ctrl.sv
cdc_fifo_dst_ctrl.sv
cdc_fifo_2phase.sv
cdc_fifo_checker.sv
cdc_fifo_tb.sv

/* Bender.yml */
package:
  name: cdc_fifo

dependencies: {}

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cdc_fifo_pkg.sv
      - fifo_mem_if.sv
      - cdc_2phase.sv
      - cdc_fifo_mem.sv
      - cdc_fifo_src_ctrl.sv
      - cdc_fifo_dst_ctrl.sv
      - cdc_fifo_2phase.sv
  - target: test
    include_dirs:
      - .
    files:
      - cdc_fifo_checker.sv
      - cdc_fifo_tb.sv

/* cdc_fifo_tb.sv */
/*
  CDC FIFO testbench
  Runs streaming, fill, drain and random-stall phases over two unrelated
  clocks and compares every popped word with a reference queue
*/
`timescale 1ns/1ps
`include "cdc_fifo_macros.svh"

module cdc_fifo_tb;
  import cdc_fifo_pkg::*;

  localparam int depth = 2 ** `CDC_FIFO_LOG_DEPTH;
  localparam int src_half_ns = 50;
  localparam int dst_half_ns = 65;
  // Two crossing round trips in slow clock cycles, with some slack
  localparam int settle_cycles = 2 * (`CDC_SYNC_STAGES + 2) + 4;
  localparam int word_time_ns = 4 * settle_cycles * dst_half_ns;

  localparam int phase_stream = 0;
  localparam int phase_fill   = 1;
  localparam int phase_drain  = 2;
  localparam int phase_random = 3;

  // Phase, word count, largest source gap and destination ready duty in percent
  localparam int n_rows = 5;
  int row_tag   [n_rows] = '{phase_stream, phase_fill, phase_drain, phase_random, phase_random};
  int row_words [n_rows] = '{40, depth, depth, 120, 80};
  int row_gap   [n_rows] = '{0, 0, 0, 3, 1};
  int row_duty  [n_rows] = '{100, 0, 100, 60, 30};

  logic  src_clk_i;
  logic  src_rst_ni;
  data_t src_data_i;
  logic  src_valid_i;
  logic  src_ready_o;
  logic  dst_clk_i;
  logic  dst_rst_ni;
  data_t dst_data_o;
  logic  dst_valid_o;
  logic  dst_ready_i;

  integer seed = 24106;
  data_t  ref_q [$];
  int     value_errors  = 0;
  int     other_errors  = 0;
  int     words_checked = 0;

  cdc_fifo_2phase DUT (
    .src_rst_ni  ( src_rst_ni  ),
    .src_clk_i   ( src_clk_i   ),
    .src_data_i  ( src_data_i  ),
    .src_valid_i ( src_valid_i ),
    .src_ready_o ( src_ready_o ),
    .dst_rst_ni  ( dst_rst_ni  ),
    .dst_clk_i   ( dst_clk_i   ),
    .dst_data_o  ( dst_data_o  ),
    .dst_valid_o ( dst_valid_o ),
    .dst_ready_i ( dst_ready_i )
  );

  initial begin
    src_clk_i = 1'b0;
    forever #(src_half_ns) src_clk_i = ~src_clk_i;
  end

  // The offset keeps every destination edge clear of every source edge
  initial begin
    dst_clk_i = 1'b0;
    #17;
    forever #(dst_half_ns) dst_clk_i = ~dst_clk_i;
  end

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    value_errors++;
    $display("FAIL t=%0t signal=%s expected=%0h actual=%0h", $time, name, expected, actual);
  endtask

  task automatic report_other(input string what);
    other_errors++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  // Pushes n words, holding each one until it is accepted
  // In the fill phase ready must stay high for all of them and drop afterwards
  task automatic push_words(input int n, input int gap, input bit fill);
    int    sent;
    bit    hold;
    data_t word;
    sent = 0;
    hold = 1'b0;
    word = data_t'($random(seed));
    while (sent < n) begin
      @(negedge src_clk_i);
      if (!hold && gap > 0 && ({$random(seed)} % (gap + 1)) != 0) begin
        src_valid_i = 1'b0;
      end else begin
        src_valid_i = 1'b1;
        src_data_i  = word;
        // Ready only changes on a source rising edge so it is settled here
        if (src_ready_o) begin
          ref_q.push_back(word);
          sent++;
          hold = 1'b0;
          word = data_t'($random(seed));
        end else if (fill) begin
          report_value("src_ready_o", 1, 0);
          break;
        end else begin
          hold = 1'b1;
        end
      end
    end
    @(negedge src_clk_i);
    src_valid_i = 1'b0;
    if (fill && src_ready_o !== 1'b0) begin
      report_value("src_ready_o", 0, src_ready_o);
    end
  endtask

  // Pops n words with ready raised at the given duty
  task automatic pop_words(input int n, input int duty);
    int    got;
    bit    ready;
    data_t expected;
    got = 0;
    while (got < n) begin
      @(negedge dst_clk_i);
      ready = (({$random(seed)} % 100) < duty);
      dst_ready_i = ready;
      if (ready && dst_valid_o) begin
        if (ref_q.size() == 0) begin
          report_other("a word was delivered that was never accepted");
        end else begin
          expected = ref_q.pop_front();
          if (dst_data_o !== expected) begin
            report_value("dst_data_o", expected, dst_data_o);
          end
        end
        got++;
        words_checked++;
      end
    end
    @(negedge dst_clk_i);
    dst_ready_i = 1'b0;
  endtask

  task automatic check_drained();
    int waited;
    waited = 0;
    while (dst_valid_o && waited < settle_cycles) begin
      @(negedge dst_clk_i);
      waited++;
    end
    if (dst_valid_o) begin
      report_other("dst_valid_o stayed high after the drain");
    end
    waited = 0;
    while (!src_ready_o && waited < 2 * settle_cycles) begin
      @(negedge src_clk_i);
      waited++;
    end
    if (!src_ready_o) begin
      report_other("src_ready_o did not rise again after the drain");
    end
  endtask

  // Lets both pointer crossings catch up before the next phase
  task automatic settle_crossings(input bit full);
    repeat (settle_cycles) @(negedge dst_clk_i);
    if (ref_q.size() == 0 && dst_valid_o) begin
      report_other("dst_valid_o is high with no word outstanding");
    end
    if (full && dst_valid_o !== 1'b1) begin
      report_value("dst_valid_o", 1, dst_valid_o);
    end
    if (full && src_ready_o !== 1'b0) begin
      report_value("src_ready_o", 0, src_ready_o);
    end
  endtask

  initial begin : main
    int r;
    int push_n;
    int pop_n;
    int total;
    src_rst_ni  = 1'b0;
    dst_rst_ni  = 1'b0;
    src_valid_i = 1'b0;
    src_data_i  = '0;
    dst_ready_i = 1'b0;
    repeat (10) @(negedge src_clk_i);
    src_rst_ni = 1'b1;
    dst_rst_ni = 1'b1;
    @(negedge src_clk_i);
    if (dst_valid_o !== 1'b0) begin
      report_value("dst_valid_o", 0, dst_valid_o);
    end
    if (src_ready_o !== 1'b1) begin
      report_value("src_ready_o", 1, src_ready_o);
    end
    for (r = 0; r < n_rows; r++) begin
      push_n = (row_tag[r] == phase_drain) ? 0 : row_words[r];
      pop_n  = (row_tag[r] == phase_fill) ? 0 : row_words[r];
      fork
        push_words(push_n, row_gap[r], row_tag[r] == phase_fill);
        pop_words(pop_n, row_duty[r]);
      join
      if (row_tag[r] == phase_drain) begin
        check_drained();
      end
      settle_crossings(row_tag[r] == phase_fill);
    end
    total = value_errors + other_errors + DUT.i_checker.fail_count;
    $display("Checked %0d words, %0d value errors, %0d other errors, %0d assertion failures",
             words_checked, value_errors, other_errors, DUT.i_checker.fail_count);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Run limit grows with the number of words in the table
  initial begin : watchdog
    int r;
    int limit_ns;
    limit_ns = 100000;
    for (r = 0; r < n_rows; r++) begin
      limit_ns += row_words[r] * word_time_ns;
    end
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* cdc_fifo_checker.sv */
/*
  CDC FIFO handshake assertions
  Bound to the top level, watches the push and pop valid/ready ports
*/
`timescale 1ns/1ps

module cdc_fifo_checker (
  input logic                src_rst_ni,
  input logic                src_clk_i,
  input logic                src_valid_i,
  input logic                src_ready_i,
  input logic                dst_rst_ni,
  input logic                dst_clk_i,
  input cdc_fifo_pkg::data_t dst_data_i,
  input logic                dst_valid_i,
  input logic                dst_ready_i
);

  // Number of assertion failures seen so far
  int unsigned fail_count = 0;

  // The head word may not move while it waits for the consumer
  hold_data: assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    (dst_valid_i && !dst_ready_i) |=> $stable(dst_data_i)
  ) else begin
    fail_count++;
    $error("dst_data_o changed while a word was waiting to be popped");
  end

  // Only a pop can take a word away from the output
  hold_valid: assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    (dst_valid_i && !dst_ready_i) |=> dst_valid_i
  ) else begin
    fail_count++;
    $error("dst_valid_o fell without a pop");
  end

  // A slot can only be used up by an accepted push
  // The read side only ever frees slots
  hold_ready: assert property (
    @(posedge src_clk_i) disable iff (!src_rst_ni)
    (src_ready_i && !src_valid_i) |=> src_ready_i
  ) else begin
    fail_count++;
    $error("src_ready_o fell without an accepted word");
  end

endmodule

bind cdc_fifo_2phase cdc_fifo_checker i_checker (
  .src_rst_ni  ( src_rst_ni  ),
  .src_clk_i   ( src_clk_i   ),
  .src_valid_i ( src_valid_i ),
  .src_ready_i ( src_ready_o ),
  .dst_rst_ni  ( dst_rst_ni  ),
  .dst_clk_i   ( dst_clk_i   ),
  .dst_data_i  ( dst_data_o  ),
  .dst_valid_i ( dst_valid_o ),
  .dst_ready_i ( dst_ready_i )
);

/* cdc_fifo_2phase.sv */
/*
  Clock domain crossing FIFO
  Valid/ready push in the source clock, valid/ready pop in the destination
  clock, with both pointers exchanged through two-phase crossings
*/
`timescale 1ns/1ps

module cdc_fifo_2phase (
  input  logic                src_rst_ni,
  input  logic                src_clk_i,
  input  cdc_fifo_pkg::data_t src_data_i,
  input  logic                src_valid_i,
  output logic                src_ready_o,

  input  logic                dst_rst_ni,
  input  logic                dst_clk_i,
  output cdc_fifo_pkg::data_t dst_data_o,
  output logic                dst_valid_o,
  input  logic                dst_ready_i
);
  import cdc_fifo_pkg::*;

  // Write pointer in its own domain and its copy in the destination domain
  pointer_t src_wptr;
  pointer_t dst_wptr;
  // Read pointer in its own domain and its copy in the source domain
  pointer_t dst_rptr;
  pointer_t src_rptr;

  // Storage ports between the controllers and the register array
  fifo_mem_if i_mem_if ();

  cdc_fifo_mem i_mem (
    .src_rst_ni ( src_rst_ni ),
    .src_clk_i  ( src_clk_i  ),
    .mem_port   ( i_mem_if   )
  );

  cdc_fifo_src_ctrl i_src_ctrl (
    .src_rst_ni  ( src_rst_ni  ),
    .src_clk_i   ( src_clk_i   ),
    .src_data_i  ( src_data_i  ),
    .src_valid_i ( src_valid_i ),
    .src_ready_o ( src_ready_o ),
    .src_rptr_i  ( src_rptr    ),
    .src_wptr_o  ( src_wptr    ),
    .wr_port     ( i_mem_if    )
  );

  cdc_fifo_dst_ctrl i_dst_ctrl (
    .dst_rst_ni  ( dst_rst_ni  ),
    .dst_clk_i   ( dst_clk_i   ),
    .dst_data_o  ( dst_data_o  ),
    .dst_valid_o ( dst_valid_o ),
    .dst_ready_i ( dst_ready_i ),
    .dst_wptr_i  ( dst_wptr    ),
    .dst_rptr_o  ( dst_rptr    ),
    .rd_port     ( i_mem_if    )
  );

  // Write pointer from the source domain into the destination domain
  cdc_2phase i_cdc_wptr (
    .src_rst_ni ( src_rst_ni ),
    .src_clk_i  ( src_clk_i  ),
    .src_data_i ( src_wptr   ),
    .dst_rst_ni ( dst_rst_ni ),
    .dst_clk_i  ( dst_clk_i  ),
    .dst_data_o ( dst_wptr   )
  );

  // Read pointer back from the destination domain into the source domain
  cdc_2phase i_cdc_rptr (
    .src_rst_ni ( dst_rst_ni ),
    .src_clk_i  ( dst_clk_i  ),
    .src_data_i ( dst_rptr   ),
    .dst_rst_ni ( src_rst_ni ),
    .dst_clk_i  ( src_clk_i  ),
    .dst_data_o ( src_rptr   )
  );

endmodule

/* cdc_fifo_dst_ctrl.sv */
/*
  CDC FIFO destination controller
  Read pointer, empty detection and the storage read port
*/
`timescale 1ns/1ps
`include "cdc_fifo_macros.svh"

module cdc_fifo_dst_ctrl (
  input  logic                   dst_rst_ni,
  input  logic                   dst_clk_i,
  output cdc_fifo_pkg::data_t    dst_data_o,
  output logic                   dst_valid_o,
  input  logic                   dst_ready_i,
  input  cdc_fifo_pkg::pointer_t dst_wptr_i,
  output cdc_fifo_pkg::pointer_t dst_rptr_o,
  fifo_mem_if.reader             rd_port
);
  import cdc_fifo_pkg::*;

  pointer_t rptr_q;
  logic     pop;

  // Anything between the pointers is waiting to be read
  // The write pointer here lags the real one, so empty is pessimistic
  assign dst_valid_o = (rptr_q != dst_wptr_i);
  assign pop         = dst_valid_o && dst_ready_i;

  // Read pointer advances with every delivered word
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      rptr_q <= '0;
    end else if (pop) begin
      rptr_q <= rptr_q + 1'b1;
    end
  end

  // Head of the FIFO is the slot under the read pointer
  assign rd_port.ridx = rptr_q[`CDC_FIFO_LOG_DEPTH-1:0];

  // The head word holds still until the pointer moves on a pop
  assign dst_data_o = rd_port.rdata;

  // Sent back to the source domain to free slots
  assign dst_rptr_o = rptr_q;

endmodule

/* cdc_fifo_src_ctrl.sv */
/*
  CDC FIFO source controller
  Write pointer, full detection and the storage write port
*/
`timescale 1ns/1ps
`include "cdc_fifo_macros.svh"

module cdc_fifo_src_ctrl (
  input  logic                   src_rst_ni,
  input  logic                   src_clk_i,
  input  cdc_fifo_pkg::data_t    src_data_i,
  input  logic                   src_valid_i,
  output logic                   src_ready_o,
  input  cdc_fifo_pkg::pointer_t src_rptr_i,
  output cdc_fifo_pkg::pointer_t src_wptr_o,
  fifo_mem_if.writer             wr_port
);
  import cdc_fifo_pkg::*;

  // Pointer distance of a full FIFO, only the wrap bit differs
  localparam pointer_t ptr_full = pointer_t'(1) << `CDC_FIFO_LOG_DEPTH;

  pointer_t wptr_q;
  logic     push;

  // Full when the indices match and the wrap bits differ
  // The read pointer here lags the real one, so full is pessimistic
  assign src_ready_o = ((wptr_q ^ src_rptr_i) != ptr_full);
  assign push        = src_valid_i && src_ready_o;

  // Write pointer advances with every accepted word
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      wptr_q <= '0;
    end else if (push) begin
      wptr_q <= wptr_q + 1'b1;
    end
  end

  // Storage write goes to the slot under the pointer
  assign wr_port.write = push;
  assign wr_port.widx  = wptr_q[`CDC_FIFO_LOG_DEPTH-1:0];
  assign wr_port.wdata = src_data_i;

  // Sent to the destination domain through a crossing
  assign src_wptr_o = wptr_q;

endmodule

/* cdc_fifo_mem.sv */
/*
  CDC FIFO storage
  Register array written from the source clock, read without a clock
*/
`timescale 1ns/1ps
`include "cdc_fifo_macros.svh"

module cdc_fifo_mem (
  input  logic       src_rst_ni,
  input  logic       src_clk_i,
  fifo_mem_if.mem    mem_port
);
  import cdc_fifo_pkg::*;

  localparam int depth = 2 ** `CDC_FIFO_LOG_DEPTH;

  // One register per slot
  data_t mem_q [depth];

  // Write port in the source domain
  // The storage starts out cleared so the read port never shows unknowns
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      for (int i = 0; i < depth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (mem_port.write) begin
      mem_q[mem_port.widx] <= mem_port.wdata;
    end
  end

  // Read port used from the destination domain
  // A slot is only read after its pointer update has crossed over, so its
  // contents have been stable for several destination cycles by then
  assign mem_port.rdata = mem_q[mem_port.ridx];

endmodule

/* cdc_2phase.sv */
/*
  Two-phase pointer crossing
  Carries one pointer value between unrelated clocks with a toggle request and
  a toggle acknowledge, re-sending the newest value after every acknowledge
*/
`timescale 1ns/1ps
`include "cdc_fifo_macros.svh"

module cdc_2phase (
  input  logic                   src_rst_ni,
  input  logic                   src_clk_i,
  input  cdc_fifo_pkg::pointer_t src_data_i,
  input  logic                   dst_rst_ni,
  input  logic                   dst_clk_i,
  output cdc_fifo_pkg::pointer_t dst_data_o
);
  import cdc_fifo_pkg::*;

  // Source domain state
  logic                         req_src_q;
  pointer_t                     data_src_q;
  logic [`CDC_SYNC_STAGES-1:0]  ack_sync_q;
  logic                         src_load;

  // Destination domain state
  logic [`CDC_SYNC_STAGES-1:0]  req_sync_q;
  logic                         ack_dst_q;
  pointer_t                     data_dst_q;
  logic                         dst_capture;

  // The source half is idle when the returned acknowledge has caught up with
  // the request, which means the last value has been taken over
  assign src_load = (req_src_q == ack_sync_q[`CDC_SYNC_STAGES-1]);

  // Acknowledge synchronizer and request toggle
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      req_src_q  <= 1'b0;
      ack_sync_q <= '0;
    end else begin
      ack_sync_q[0] <= ack_dst_q;
      for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
        ack_sync_q[i] <= ack_sync_q[i-1];
      end
      // Flipping the request starts a new transfer
      if (src_load) begin
        req_src_q <= ~req_src_q;
      end
    end
  end

  // Data register for the transfer in flight
  // It only loads while no request is outstanding, so the destination always
  // samples a settled value
  always_ff @(posedge src_clk_i) begin
    if (src_load) begin
      data_src_q <= src_data_i;
    end
  end

  // A request toggle that differs from the own acknowledge is a new transfer
  assign dst_capture = (req_sync_q[`CDC_SYNC_STAGES-1] != ack_dst_q);

  // Request synchronizer, output register and acknowledge toggle
  // The output register resets to zero so both FIFO pointers start equal
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      req_sync_q <= '0;
      ack_dst_q  <= 1'b0;
      data_dst_q <= '0;
    end else begin
      req_sync_q[0] <= req_src_q;
      for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
        req_sync_q[i] <= req_sync_q[i-1];
      end
      if (dst_capture) begin
        // Taking the word and answering happen in the same edge
        data_dst_q <= data_src_q;
        ack_dst_q  <= ~ack_dst_q;
      end
    end
  end

  // The value seen by the far domain only changes when a transfer completes
  assign dst_data_o = data_dst_q;

endmodule

/* fifo_mem_if.sv */
/*
  FIFO storage port bundle
  Write port from the source controller, read port from the destination one
*/
`timescale 1ns/1ps

interface fifo_mem_if;
  import cdc_fifo_pkg::*;

  // Write strobe, written in the source clock domain
  logic   write;
  // Slot addressed by the write
  index_t widx;
  // Word stored on the write
  data_t  wdata;
  // Slot addressed by the combinational read
  index_t ridx;
  // Word currently held at ridx
  data_t  rdata;

  // Source controller side
  modport writer (
    output write,
    output widx,
    output wdata
  );

  // Destination controller side
  modport reader (
    output ridx,
    input  rdata
  );

  // Storage side, the reverse of both controllers
  modport mem (
    input  write,
    input  widx,
    input  wdata,
    input  ridx,
    output rdata
  );

endinterface

/* cdc_fifo_pkg.sv */
/*
  CDC FIFO type package
  Payload, storage index and pointer types derived from the build macros
*/
`include "cdc_fifo_macros.svh"

package cdc_fifo_pkg;

  // One payload word as it is pushed and popped
  typedef logic [`CDC_FIFO_DATA_WIDTH-1:0] data_t;

  // Address of one storage slot
  typedef logic [`CDC_FIFO_LOG_DEPTH-1:0] index_t;

  // FIFO pointer, one bit wider than the index
  // The top bit is the wrap bit and flips on every lap through the storage,
  // so equal indices with differing wrap bits mean full and equal pointers
  // mean empty
  typedef logic [`CDC_FIFO_LOG_DEPTH:0] pointer_t;

endpackage

/* cdc_fifo_macros.svh */
/*
  CDC FIFO build parameters
  Payload width, FIFO depth and synchronizer length shared by every block
*/
`ifndef CDC_FIFO_MACROS_SVH
`define CDC_FIFO_MACROS_SVH

// Width of one payload word in bits
`define CDC_FIFO_DATA_WIDTH 16

// The FIFO holds 2**LOG_DEPTH words and LOG_DEPTH has to be 1 or more
`define CDC_FIFO_LOG_DEPTH 3

// Flip-flops in each toggle synchronizer of the pointer crossings
// Two is the usual minimum for metastability settling
`define CDC_SYNC_STAGES 2

`endif
